//--- src/bus_pkg.sv
// bus definitions for the main board glue
// payload types of the 68k and Z80 buses and their driver counts
package bus_pkg;

	// 68k side
	typedef logic [15:0] vdata_t;
	typedef logic [22:0] vaddr_t;

	// Z80 side
	typedef logic [7:0] zdata_t;
	typedef logic [15:0] zaddr_t;

	// work RAM and sound RAM address ports
	typedef logic [14:0] ram68_addr_t;
	typedef logic [12:0] zram_addr_t;

	// number of drivers on each merged bus
	localparam int unsigned VD_SOURCES = 4;
	localparam int unsigned VA_SOURCES = 2;
	localparam int unsigned ZD_SOURCES = 3;
	localparam int unsigned ZA_SOURCES = 2;

	// slot order of the 68k data drivers
	typedef enum logic [1:0] {VD_CHIP, VD_CPU, VD_RAM, VD_CART} vd_src_e;

endpackage

//--- src/audio_pkg.sv
// audio definitions for the main board glue
// sample formats of the FM and PSG outputs and the mix gains
package audio_pkg;

	// ym3438 style linear output, unsigned
	typedef logic [8:0] fm_lin_t;
	// ym2612 dac emulation, two's complement
	typedef logic signed [9:0] fm_dac_t;
	typedef logic [15:0] psg_t;
	typedef logic [15:0] mix_t;
	typedef logic [17:0] mix2612_t;

	// midpoint of the linear FM range
	localparam fm_lin_t FM_BIAS = 9'd256;

	// linear gain of 64
	localparam int LIN_SHIFT = 6;
	// dac gain of 192 as 128 plus 64
	localparam int DAC_HI_SHIFT = 7;
	localparam int DAC_LO_SHIFT = 6;

endpackage

//--- src/bus_merge.sv
// wired-OR bus merge
// registers the OR of all driven sources every cycle
// undriven bits keep their value or float high
module bus_merge #(
	parameter type payload_t = logic [7:0],
	parameter int N_SRC = 2,
	parameter bit HOLD_IDLE = 1'b1
) (
	input  logic MCLK2,
	input  logic reset_i,
	input  payload_t src_val_i [N_SRC],
	input  payload_t src_rel_i [N_SRC],
	output payload_t bus_o
);
	localparam payload_t IDLE_VALUE = HOLD_IDLE ? payload_t'(0) : ~payload_t'(0);

	payload_t driven;
	payload_t all_rel;
	payload_t idle_fill;

	always_comb
	begin
		driven = '0;
		all_rel = '1;
		for (int i = 0; i < N_SRC; i++)
		begin
			driven = driven | (src_val_i[i] & ~src_rel_i[i]);
			all_rel = all_rel & src_rel_i[i];
		end
	end

	// bus keeper or pull-up on floating bits
	assign idle_fill = HOLD_IDLE ? bus_o : IDLE_VALUE;

	always_ff @(posedge MCLK2)
	begin
		if (reset_i)
			bus_o <= IDLE_VALUE;
		else
			bus_o <= driven | (all_rel & idle_fill);
	end

	generate
		if (HOLD_IDLE)
		begin : g_hold_check
			// bits nobody drove last cycle must not move
			a_hold_idle: assert property (@(posedge MCLK2) disable iff (reset_i)
				!$past(reset_i) |-> (($past(all_rel) & (bus_o ^ $past(bus_o))) == '0));
		end
	endgenerate

endmodule

//--- src/bus_ctrl.sv
// bus control for the 68k and Z80 sides
// merges the strobes, registers acknowledge and request lines,
// builds the data lane release masks and maps both RAM ports
module bus_ctrl (
	input  logic MCLK2,
	input  logic reset_i,
	input  logic ym_as_i, ym_uds_i, ym_lds_i, ym_strobe_rel_i,
	input  logic cpu_as_i, cpu_uds_i, cpu_lds_i, cpu_strobe_rel_i,
	input  logic ym_rw_i, ym_rw_rel_i, cpu_rw_i, cpu_rw_rel_i,
	input  logic ym_zrd_i, ym_zwr_i, ym_mreq_i, ym_zstb_rel_i,
	input  logic z80_zrd_i, z80_zwr_i, z80_mreq_i, z80_zstb_rel_i,
	input  logic z80_iorq_i, z80_iorq_rel_i,
	input  logic ym_dtack_pull_i, ext_dtack_i, ym_bgack_pull_i, ym_br_pull_i,
	input  logic ym_reset_pull_i, cpu_reset_pull_i, ym_halt_pull_i, cpu_halt_pull_i,
	input  logic ext_vres_i,
	input  logic eoe_i, noe_i, ras0_i, uwr_i, lwr_i, ia14_i, zram_i,
	input  logic m3_i, cart_data_en_i,
	input  bus_pkg::vaddr_t va_i,
	input  bus_pkg::vdata_t vd_i,
	input  bus_pkg::zaddr_t za_i,
	input  bus_pkg::zdata_t zd_i,
	output logic as_n_o, uds_n_o, lds_n_o, rw_o,
	output logic zrd_n_o, zwr_n_o, mreq_n_o, iorq_n_o,
	output logic dtack_n_o, bgack_n_o, br_n_o,
	output logic reset_n_o, halt_n_o,
	output bus_pkg::vdata_t ram_vd_rel_o,
	output bus_pkg::vdata_t cart_vd_rel_o,
	output logic ram_zd_rel_o,
	output bus_pkg::ram68_addr_t ram_68k_address_o,
	output logic [1:0] ram_68k_byteena_o,
	output bus_pkg::vdata_t ram_68k_data_o,
	output logic ram_68k_wren_o,
	output bus_pkg::zram_addr_t ram_z80_address_o,
	output bus_pkg::zdata_t ram_z80_data_o,
	output logic ram_z80_wren_o
);
	import bus_pkg::*;

	localparam int LANE_W = $bits(vdata_t) / 2;
	localparam int ZRAM_AW = $bits(zram_addr_t);

	logic m3_q;
	logic [LANE_W-1:0] cart_lane_rel;

	// two open-drain style drivers, idle high when both let go
	function automatic logic strobe_merge(input logic a, input logic a_rel,
		input logic b, input logic b_rel);
		if (a_rel && b_rel)
			return 1'b1;
		return (~a_rel & a) | (~b_rel & b);
	endfunction

	always_ff @(posedge MCLK2)
	begin
		if (reset_i)
		begin
			as_n_o <= 1'b1;
			uds_n_o <= 1'b1;
			lds_n_o <= 1'b1;
			rw_o <= 1'b1;
			zrd_n_o <= 1'b1;
			zwr_n_o <= 1'b1;
			mreq_n_o <= 1'b1;
			iorq_n_o <= 1'b1;
			dtack_n_o <= 1'b1;
			bgack_n_o <= 1'b1;
			br_n_o <= 1'b1;
			m3_q <= 1'b0;
		end
		else
		begin
			as_n_o <= strobe_merge(ym_as_i, ym_strobe_rel_i, cpu_as_i, cpu_strobe_rel_i);
			uds_n_o <= strobe_merge(ym_uds_i, ym_strobe_rel_i, cpu_uds_i, cpu_strobe_rel_i);
			lds_n_o <= strobe_merge(ym_lds_i, ym_strobe_rel_i, cpu_lds_i, cpu_strobe_rel_i);
			rw_o <= strobe_merge(ym_rw_i, ym_rw_rel_i, cpu_rw_i, cpu_rw_rel_i);
			zrd_n_o <= strobe_merge(ym_zrd_i, ym_zstb_rel_i, z80_zrd_i, z80_zstb_rel_i);
			zwr_n_o <= strobe_merge(ym_zwr_i, ym_zstb_rel_i, z80_zwr_i, z80_zstb_rel_i);
			mreq_n_o <= strobe_merge(ym_mreq_i, ym_zstb_rel_i, z80_mreq_i, z80_zstb_rel_i);
			// only the Z80 drives iorq
			iorq_n_o <= z80_iorq_rel_i ? 1'b1 : z80_iorq_i;
			dtack_n_o <= ~(ym_dtack_pull_i | ext_dtack_i);
			bgack_n_o <= ~ym_bgack_pull_i;
			br_n_o <= ~ym_br_pull_i;
			m3_q <= m3_i;
		end
	end

	assign reset_n_o = ~(ym_reset_pull_i | cpu_reset_pull_i | ext_vres_i);
	assign halt_n_o = ~(ym_halt_pull_i | cpu_halt_pull_i | ext_vres_i);

	// work RAM lanes follow the chip's output enables
	assign ram_vd_rel_o = {{LANE_W{eoe_i | ras0_i}}, {LANE_W{noe_i | ras0_i}}};

	// cartridge drives both lanes only in M3 mode
	assign cart_lane_rel = {LANE_W{~cart_data_en_i}};
	assign cart_vd_rel_o = m3_q ? {cart_lane_rel, cart_lane_rel}
		: {{LANE_W{1'b1}}, cart_lane_rel};

	assign ram_zd_rel_o = zrd_n_o | zram_i;

	// 68k work RAM, bit 13 comes from the chip's ia14
	assign ram_68k_address_o = {va_i[14], ia14_i, va_i[12:0]};
	assign ram_68k_byteena_o = {~uwr_i, ~lwr_i};
	assign ram_68k_data_o = vd_i;
	assign ram_68k_wren_o = (~uwr_i | ~lwr_i) & ~ras0_i;

	assign ram_z80_address_o = za_i[ZRAM_AW-1:0];
	assign ram_z80_data_o = zd_i;
	assign ram_z80_wren_o = ~zram_i & ~zwr_n_o;

	// sound RAM never written during a Z80 read cycle
	a_zram_rd_wr: assert property (@(posedge MCLK2) disable iff (reset_i)
		!(ram_z80_wren_o && !zrd_n_o));

endmodule

//--- src/audio_mix.sv
// stereo audio mixer
// adds the PSG sample to the linear FM output
// and separately to the ym2612 dac emulation output
module audio_mix (
	input  audio_pkg::fm_lin_t mol_i, mor_i,
	input  audio_pkg::fm_dac_t mol_2612_i, mor_2612_i,
	input  audio_pkg::psg_t psg_i,
	output audio_pkg::mix_t a_l_o, a_r_o,
	output audio_pkg::mix2612_t a_l_2612_o, a_r_2612_o
);
	import audio_pkg::*;

	// recentre the unsigned sample, then scale by 64
	function automatic mix_t lin_mix(input fm_lin_t fm, input psg_t psg);
		logic signed [$bits(fm_lin_t)-1:0] centred;
		mix_t wide;
		centred = fm - FM_BIAS;
		wide = mix_t'(centred);
		return (wide << LIN_SHIFT) + psg;
	endfunction

	// signed sample times 192, psg added unsigned
	function automatic mix2612_t dac_mix(input fm_dac_t fm, input psg_t psg);
		mix2612_t wide;
		wide = mix2612_t'(fm);
		return (wide << DAC_HI_SHIFT) + (wide << DAC_LO_SHIFT) + mix2612_t'(psg);
	endfunction

	// linear FM path
	assign a_l_o = lin_mix(mol_i, psg_i);
	assign a_r_o = lin_mix(mor_i, psg_i);

	// dac emulation path
	assign a_l_2612_o = dac_mix(mol_2612_i, psg_i);
	assign a_r_2612_o = dac_mix(mor_2612_i, psg_i);

endmodule

//--- src/md_glue.sv
// console main board glue
// collects the bus drivers of chip, CPUs, RAMs and cartridge,
// merges them into the 68k and Z80 buses and mixes the audio
module md_glue (
	input  logic MCLK2,
	input  logic reset_i,
	// 68k and Z80 strobe drivers
	input  logic ym_as_i, ym_uds_i, ym_lds_i, ym_strobe_rel_i,
	input  logic cpu_as_i, cpu_uds_i, cpu_lds_i, cpu_strobe_rel_i,
	input  logic ym_rw_i, ym_rw_rel_i, cpu_rw_i, cpu_rw_rel_i,
	input  logic ym_zrd_i, ym_zwr_i, ym_mreq_i, ym_zstb_rel_i,
	input  logic z80_zrd_i, z80_zwr_i, z80_mreq_i, z80_zstb_rel_i,
	input  logic z80_iorq_i, z80_iorq_rel_i,
	// acknowledge, request, reset and halt pulls
	input  logic ym_dtack_pull_i, ext_dtack_i, ym_bgack_pull_i, ym_br_pull_i,
	input  logic ym_reset_pull_i, cpu_reset_pull_i, ym_halt_pull_i, cpu_halt_pull_i,
	input  logic ext_vres_i,
	// RAM decode and cartridge
	input  logic eoe_i, noe_i, ras0_i, uwr_i, lwr_i, ia14_i, zram_i,
	input  logic m3_i, cart_data_en_i,
	// 68k data drivers, per bit release
	input  bus_pkg::vdata_t ym_vd_i, ym_vd_rel_i,
	input  bus_pkg::vdata_t cpu_vd_i, cpu_vd_rel_i,
	input  bus_pkg::vdata_t ram_68k_q_i, cart_data_i,
	// 68k address drivers
	input  bus_pkg::vaddr_t ym_va_i, cpu_va_i,
	input  logic ym_va_rel_i, cpu_va_rel_i,
	// Z80 data and address drivers
	input  bus_pkg::zdata_t ym_zd_i, z80_zd_i, ram_z80_q_i,
	input  logic ym_zd_rel_i, z80_zd_rel_i,
	input  bus_pkg::zaddr_t ym_za_i, z80_za_i,
	input  logic ym_za_rel_i, z80_za_rel_i,
	// sound chip samples
	input  audio_pkg::fm_lin_t mol_i, mor_i,
	input  audio_pkg::fm_dac_t mol_2612_i, mor_2612_i,
	input  audio_pkg::psg_t psg_i,
	// merged buses
	output bus_pkg::vdata_t vd_o,
	output bus_pkg::vaddr_t va_o,
	output bus_pkg::zdata_t zd_o,
	output bus_pkg::zaddr_t za_o,
	// merged strobes and control lines
	output logic as_n_o, uds_n_o, lds_n_o, rw_o,
	output logic zrd_n_o, zwr_n_o, mreq_n_o, iorq_n_o,
	output logic dtack_n_o, bgack_n_o, br_n_o,
	output logic reset_n_o, halt_n_o,
	// RAM ports
	output bus_pkg::ram68_addr_t ram_68k_address_o,
	output logic [1:0] ram_68k_byteena_o,
	output bus_pkg::vdata_t ram_68k_data_o,
	output logic ram_68k_wren_o,
	output bus_pkg::zram_addr_t ram_z80_address_o,
	output bus_pkg::zdata_t ram_z80_data_o,
	output logic ram_z80_wren_o,
	// audio
	output audio_pkg::mix_t a_l_o, a_r_o,
	output audio_pkg::mix2612_t a_l_2612_o, a_r_2612_o
);
	import bus_pkg::*;

	vdata_t vd_val [VD_SOURCES];
	vdata_t vd_rel [VD_SOURCES];
	vaddr_t va_val [VA_SOURCES];
	vaddr_t va_rel [VA_SOURCES];
	zdata_t zd_val [ZD_SOURCES];
	zdata_t zd_rel [ZD_SOURCES];
	zaddr_t za_val [ZA_SOURCES];
	zaddr_t za_rel [ZA_SOURCES];
	vdata_t ram_vd_rel;
	vdata_t cart_vd_rel;
	logic ram_zd_rel;

	// 68k data slots
	assign vd_val[VD_CHIP] = ym_vd_i;
	assign vd_rel[VD_CHIP] = ym_vd_rel_i;
	assign vd_val[VD_CPU] = cpu_vd_i;
	assign vd_rel[VD_CPU] = cpu_vd_rel_i;
	assign vd_val[VD_RAM] = ram_68k_q_i;
	assign vd_rel[VD_RAM] = ram_vd_rel;
	assign vd_val[VD_CART] = cart_data_i;
	assign vd_rel[VD_CART] = cart_vd_rel;

	// single release flags widened to the bus
	assign va_val[0] = ym_va_i;
	assign va_rel[0] = {$bits(vaddr_t){ym_va_rel_i}};
	assign va_val[1] = cpu_va_i;
	assign va_rel[1] = {$bits(vaddr_t){cpu_va_rel_i}};

	assign zd_val[0] = ym_zd_i;
	assign zd_rel[0] = {$bits(zdata_t){ym_zd_rel_i}};
	assign zd_val[1] = z80_zd_i;
	assign zd_rel[1] = {$bits(zdata_t){z80_zd_rel_i}};
	assign zd_val[2] = ram_z80_q_i;
	assign zd_rel[2] = {$bits(zdata_t){ram_zd_rel}};

	assign za_val[0] = ym_za_i;
	assign za_rel[0] = {$bits(zaddr_t){ym_za_rel_i}};
	assign za_val[1] = z80_za_i;
	assign za_rel[1] = {$bits(zaddr_t){z80_za_rel_i}};

	bus_ctrl u_ctrl (
		.*,
		.va_i(va_o),
		.vd_i(vd_o),
		.za_i(za_o),
		.zd_i(zd_o),
		.ram_vd_rel_o(ram_vd_rel),
		.cart_vd_rel_o(cart_vd_rel),
		.ram_zd_rel_o(ram_zd_rel)
	);

	bus_merge #(.payload_t(vdata_t), .N_SRC(VD_SOURCES), .HOLD_IDLE(1'b1)) u_vd (
		.MCLK2(MCLK2),
		.reset_i(reset_i),
		.src_val_i(vd_val),
		.src_rel_i(vd_rel),
		.bus_o(vd_o)
	);

	bus_merge #(.payload_t(vaddr_t), .N_SRC(VA_SOURCES), .HOLD_IDLE(1'b1)) u_va (
		.MCLK2(MCLK2),
		.reset_i(reset_i),
		.src_val_i(va_val),
		.src_rel_i(va_rel),
		.bus_o(va_o)
	);

	// Z80 data has pull-ups, an idle bus reads as ones
	bus_merge #(.payload_t(zdata_t), .N_SRC(ZD_SOURCES), .HOLD_IDLE(1'b0)) u_zd (
		.MCLK2(MCLK2),
		.reset_i(reset_i),
		.src_val_i(zd_val),
		.src_rel_i(zd_rel),
		.bus_o(zd_o)
	);

	bus_merge #(.payload_t(zaddr_t), .N_SRC(ZA_SOURCES), .HOLD_IDLE(1'b1)) u_za (
		.MCLK2(MCLK2),
		.reset_i(reset_i),
		.src_val_i(za_val),
		.src_rel_i(za_rel),
		.bus_o(za_o)
	);

	audio_mix u_mix (.*);

endmodule

//--- bench/tb_md_glue.sv
// testbench for the main board glue
// drives random bus, strobe and audio traffic while assertions
// compare every output with a reference model of the glue rules
module tb_md_glue;
	timeunit 1ns;
	timeprecision 100ps;

	import bus_pkg::*;
	import audio_pkg::*;

	localparam int WAIT_LIMIT = 50;

	logic MCLK2 = 1'b0;
	logic reset_i;
	logic ym_as_i, ym_uds_i, ym_lds_i, ym_strobe_rel_i;
	logic cpu_as_i, cpu_uds_i, cpu_lds_i, cpu_strobe_rel_i;
	logic ym_rw_i, ym_rw_rel_i, cpu_rw_i, cpu_rw_rel_i;
	logic ym_zrd_i, ym_zwr_i, ym_mreq_i, ym_zstb_rel_i;
	logic z80_zrd_i, z80_zwr_i, z80_mreq_i, z80_zstb_rel_i;
	logic z80_iorq_i, z80_iorq_rel_i;
	logic ym_dtack_pull_i, ext_dtack_i, ym_bgack_pull_i, ym_br_pull_i;
	logic ym_reset_pull_i, cpu_reset_pull_i, ym_halt_pull_i, cpu_halt_pull_i;
	logic ext_vres_i;
	logic eoe_i, noe_i, ras0_i, uwr_i, lwr_i, ia14_i, zram_i;
	logic m3_i, cart_data_en_i;
	vdata_t ym_vd_i, ym_vd_rel_i, cpu_vd_i, cpu_vd_rel_i, ram_68k_q_i, cart_data_i;
	vaddr_t ym_va_i, cpu_va_i;
	logic ym_va_rel_i, cpu_va_rel_i;
	zdata_t ym_zd_i, z80_zd_i, ram_z80_q_i;
	logic ym_zd_rel_i, z80_zd_rel_i;
	zaddr_t ym_za_i, z80_za_i;
	logic ym_za_rel_i, z80_za_rel_i;
	fm_lin_t mol_i, mor_i;
	fm_dac_t mol_2612_i, mor_2612_i;
	psg_t psg_i;
	vdata_t vd_o;
	vaddr_t va_o;
	zdata_t zd_o;
	zaddr_t za_o;
	logic as_n_o, uds_n_o, lds_n_o, rw_o, zrd_n_o, zwr_n_o, mreq_n_o, iorq_n_o;
	logic dtack_n_o, bgack_n_o, br_n_o, reset_n_o, halt_n_o;
	ram68_addr_t ram_68k_address_o;
	logic [1:0] ram_68k_byteena_o;
	vdata_t ram_68k_data_o;
	logic ram_68k_wren_o;
	zram_addr_t ram_z80_address_o;
	zdata_t ram_z80_data_o;
	logic ram_z80_wren_o;
	mix_t a_l_o, a_r_o;
	mix2612_t a_l_2612_o, a_r_2612_o;

	integer seed = 32'ha246_e39c;
	int errors = 0;
	int tests_done = 0;

	// reference model state and next values
	vdata_t exp_vd, vd_next, ram_rel, cart_rel;
	vaddr_t exp_va, va_next;
	zdata_t exp_zd, zd_drv;
	zaddr_t exp_za, za_next;
	// msb first as uds lds rw zrd zwr mreq iorq dtack bgack br
	logic [10:0] exp_ctl, dut_ctl;
	logic exp_m3, zram_rel, zd_idle;
	logic [1:0] rst_halt_exp;
	logic [33:0] ram68_got, ram68_exp;
	logic [21:0] zram_got, zram_exp;
	logic [31:0] lin_got, lin_exp;
	logic [35:0] dac_got, dac_exp;

	md_glue dut0 (.*);

	always #4 MCLK2 = ~MCLK2;

	function automatic logic strobe_expect(input logic a, input logic a_rel,
		input logic b, input logic b_rel);
		if (a_rel && b_rel)
			return 1'b1;
		return (a && !a_rel) || (b && !b_rel);
	endfunction

	function automatic mix_t lin_expect(input fm_lin_t fm, input psg_t psg);
		int v;
		v = (int'(fm) - int'(FM_BIAS)) * 64 + int'(psg);
		return v[15:0];
	endfunction

	function automatic mix2612_t dac_expect(input fm_dac_t fm, input psg_t psg);
		int v;
		v = int'(fm) * 192 + int'(psg);
		return v[17:0];
	endfunction

	// lane masks of work RAM and cartridge
	assign ram_rel = {{8{eoe_i | ras0_i}}, {8{noe_i | ras0_i}}};
	assign cart_rel = {exp_m3 ? {8{!cart_data_en_i}} : 8'hff, {8{!cart_data_en_i}}};
	assign vd_next = (ym_vd_i & ~ym_vd_rel_i) | (cpu_vd_i & ~cpu_vd_rel_i)
		| (ram_68k_q_i & ~ram_rel) | (cart_data_i & ~cart_rel)
		| (ym_vd_rel_i & cpu_vd_rel_i & ram_rel & cart_rel & exp_vd);
	assign va_next = (ym_va_rel_i && cpu_va_rel_i) ? exp_va
		: ((ym_va_i & {23{!ym_va_rel_i}}) | (cpu_va_i & {23{!cpu_va_rel_i}}));
	assign za_next = (ym_za_rel_i && z80_za_rel_i) ? exp_za
		: ((ym_za_i & {16{!ym_za_rel_i}}) | (z80_za_i & {16{!z80_za_rel_i}}));
	// sound RAM drives only during a Z80 read of its window
	assign zram_rel = exp_ctl[6] | zram_i;
	assign zd_idle = ym_zd_rel_i & z80_zd_rel_i & zram_rel;
	assign zd_drv = (ym_zd_i & {8{!ym_zd_rel_i}}) | (z80_zd_i & {8{!z80_zd_rel_i}})
		| (ram_z80_q_i & {8{!zram_rel}});

	assign dut_ctl = {as_n_o, uds_n_o, lds_n_o, rw_o, zrd_n_o, zwr_n_o, mreq_n_o, iorq_n_o,
		dtack_n_o, bgack_n_o, br_n_o};
	assign rst_halt_exp = {!(ym_reset_pull_i || cpu_reset_pull_i || ext_vres_i),
		!(ym_halt_pull_i || cpu_halt_pull_i || ext_vres_i)};
	assign ram68_got = {ram_68k_address_o, ram_68k_byteena_o, ram_68k_wren_o, ram_68k_data_o};
	assign ram68_exp = {exp_va[14], ia14_i, exp_va[12:0], !uwr_i, !lwr_i,
		(!uwr_i || !lwr_i) && !ras0_i, exp_vd};
	assign zram_got = {ram_z80_address_o, ram_z80_data_o, ram_z80_wren_o};
	assign zram_exp = {exp_za[12:0], exp_zd, !zram_i && !exp_ctl[5]};
	assign lin_got = {a_l_o, a_r_o};
	assign lin_exp = {lin_expect(mol_i, psg_i), lin_expect(mor_i, psg_i)};
	assign dac_got = {a_l_2612_o, a_r_2612_o};
	assign dac_exp = {dac_expect(mol_2612_i, psg_i), dac_expect(mor_2612_i, psg_i)};

	always @(posedge MCLK2)
	begin
		if (reset_i)
		begin
			exp_vd <= '0;
			exp_va <= '0;
			exp_zd <= '1;
			exp_za <= '0;
			exp_ctl <= '1;
			exp_m3 <= 1'b0;
		end
		else
		begin
			exp_vd <= vd_next;
			exp_va <= va_next;
			exp_zd <= zd_idle ? 8'hff : zd_drv;
			exp_za <= za_next;
			exp_ctl <= {strobe_expect(ym_as_i, ym_strobe_rel_i, cpu_as_i, cpu_strobe_rel_i),
				strobe_expect(ym_uds_i, ym_strobe_rel_i, cpu_uds_i, cpu_strobe_rel_i),
				strobe_expect(ym_lds_i, ym_strobe_rel_i, cpu_lds_i, cpu_strobe_rel_i),
				strobe_expect(ym_rw_i, ym_rw_rel_i, cpu_rw_i, cpu_rw_rel_i),
				strobe_expect(ym_zrd_i, ym_zstb_rel_i, z80_zrd_i, z80_zstb_rel_i),
				strobe_expect(ym_zwr_i, ym_zstb_rel_i, z80_zwr_i, z80_zstb_rel_i),
				strobe_expect(ym_mreq_i, ym_zstb_rel_i, z80_mreq_i, z80_zstb_rel_i),
				z80_iorq_rel_i | z80_iorq_i,
				!(ym_dtack_pull_i || ext_dtack_i), !ym_bgack_pull_i, !ym_br_pull_i};
			exp_m3 <= m3_i;
		end
	end

	task automatic log_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		errors++;
		$display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
	endtask

	a_reset_idle: assert property (@(posedge MCLK2) $fell(reset_i) |->
		(dut_ctl == '1 && zd_o == 8'hff && !ram_68k_wren_o && !ram_z80_wren_o))
		else
		begin
			errors++;
			$display("outputs were not idle right after reset at %0t", $time);
		end
	a_vd: assert property (@(posedge MCLK2) disable iff (reset_i) vd_o == exp_vd)
		else log_mismatch("vd_o", 64'($sampled(vd_o)), 64'($sampled(exp_vd)));
	a_va: assert property (@(posedge MCLK2) disable iff (reset_i) va_o == exp_va)
		else log_mismatch("va_o", 64'($sampled(va_o)), 64'($sampled(exp_va)));
	a_zd: assert property (@(posedge MCLK2) disable iff (reset_i) zd_o == exp_zd)
		else log_mismatch("zd_o", 64'($sampled(zd_o)), 64'($sampled(exp_zd)));
	a_za: assert property (@(posedge MCLK2) disable iff (reset_i) za_o == exp_za)
		else log_mismatch("za_o", 64'($sampled(za_o)), 64'($sampled(exp_za)));
	a_ctl: assert property (@(posedge MCLK2) disable iff (reset_i) dut_ctl == exp_ctl)
		else log_mismatch("strobes", 64'($sampled(dut_ctl)), 64'($sampled(exp_ctl)));
	a_reset_halt: assert property (@(posedge MCLK2) disable iff (reset_i)
		{reset_n_o, halt_n_o} == rst_halt_exp)
		else log_mismatch("reset_n_o/halt_n_o", 64'($sampled({reset_n_o, halt_n_o})),
			64'($sampled(rst_halt_exp)));
	a_ram68: assert property (@(posedge MCLK2) disable iff (reset_i) ram68_got == ram68_exp)
		else log_mismatch("ram_68k port", 64'($sampled(ram68_got)), 64'($sampled(ram68_exp)));
	a_zram: assert property (@(posedge MCLK2) disable iff (reset_i) zram_got == zram_exp)
		else log_mismatch("ram_z80 port", 64'($sampled(zram_got)), 64'($sampled(zram_exp)));
	a_lin: assert property (@(posedge MCLK2) disable iff (reset_i) lin_got == lin_exp)
		else log_mismatch("a_l_o/a_r_o", 64'($sampled(lin_got)), 64'($sampled(lin_exp)));
	a_dac: assert property (@(posedge MCLK2) disable iff (reset_i) dac_got == dac_exp)
		else log_mismatch("a_l_2612_o/a_r_2612_o", 64'($sampled(dac_got)),
			64'($sampled(dac_exp)));

	task automatic end_run();
		$display("tests run %0d, errors %0d", tests_done, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d %s finished, errors so far %0d", tests_done, name, errors);
	endtask

	task automatic next_cycle();
		@(posedge MCLK2);
		#1;
	endtask

	task automatic wait_zd_ones(input string what, output bit ok);
		int n;
		n = 0;
		while (zd_o !== 8'hff && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
		end
		ok = (zd_o === 8'hff);
		if (!ok)
		begin
			$display("timeout: Z80 data bus never floated high after %s", what);
			errors++;
		end
	endtask

	// every driver released and every strobe and pull inactive
	task automatic set_idle();
		{ym_as_i, ym_uds_i, ym_lds_i, ym_strobe_rel_i} = 4'hf;
		{cpu_as_i, cpu_uds_i, cpu_lds_i, cpu_strobe_rel_i} = 4'hf;
		{ym_rw_i, ym_rw_rel_i, cpu_rw_i, cpu_rw_rel_i} = 4'hf;
		{ym_zrd_i, ym_zwr_i, ym_mreq_i, ym_zstb_rel_i} = 4'hf;
		{z80_zrd_i, z80_zwr_i, z80_mreq_i, z80_zstb_rel_i} = 4'hf;
		{z80_iorq_i, z80_iorq_rel_i} = 2'b11;
		{ym_dtack_pull_i, ext_dtack_i, ym_bgack_pull_i, ym_br_pull_i} = 4'h0;
		{ym_reset_pull_i, cpu_reset_pull_i, ym_halt_pull_i, cpu_halt_pull_i} = 4'h0;
		ext_vres_i = 1'b0;
		{eoe_i, noe_i, ras0_i, uwr_i, lwr_i, zram_i} = 6'h3f;
		{ia14_i, m3_i, cart_data_en_i} = 3'b000;
		{ym_vd_i, cpu_vd_i, ram_68k_q_i, cart_data_i} = '0;
		{ym_vd_rel_i, cpu_vd_rel_i} = '1;
		{ym_va_i, cpu_va_i, ym_zd_i, z80_zd_i, ram_z80_q_i, ym_za_i, z80_za_i} = '0;
		{ym_va_rel_i, cpu_va_rel_i, ym_zd_rel_i, z80_zd_rel_i, ym_za_rel_i, z80_za_rel_i} = '1;
		{mol_i, mor_i, mol_2612_i, mor_2612_i, psg_i} = '0;
	endtask

	// one Z80 cycle type per driver so read and write never meet
	task automatic drive_z_ops(input logic [1:0] ym_op, input logic [1:0] z80_op);
		ym_zrd_i = (ym_op != 2'd1);
		ym_zwr_i = (ym_op != 2'd2);
		z80_zrd_i = (z80_op != 2'd1);
		z80_zwr_i = (z80_op != 2'd2);
	endtask

	task automatic rand_buses();
		logic [31:0] r;
		logic [31:0] s;
		r = $random(seed);
		s = $random(seed);
		{cpu_vd_i, ym_vd_i} = r;
		{cpu_vd_rel_i, ym_vd_rel_i} = s;
		r = $random(seed);
		{cart_data_i, ram_68k_q_i} = r;
		r = $random(seed);
		ym_va_i = r[22:0];
		{eoe_i, noe_i, ras0_i, cart_data_en_i, m3_i} = r[27:23];
		{ym_va_rel_i, cpu_va_rel_i, ym_za_rel_i, z80_za_rel_i} = r[31:28];
		r = $random(seed);
		cpu_va_i = r[22:0];
		r = $random(seed);
		{z80_za_i, ym_za_i} = r;
	endtask

	task automatic rand_zdata();
		logic [31:0] r;
		r = $random(seed);
		{ram_z80_q_i, z80_zd_i, ym_zd_i} = r[23:0];
		{ym_zd_rel_i, z80_zd_rel_i, zram_i} = r[26:24];
		ym_zstb_rel_i = r[31];
		z80_zstb_rel_i = 1'b0;
		drive_z_ops(r[28:27], r[30:29]);
	endtask

	task automatic rand_strobes();
		logic [31:0] r;
		r = $random(seed);
		{ym_as_i, ym_uds_i, ym_lds_i, ym_strobe_rel_i} = r[3:0];
		{cpu_as_i, cpu_uds_i, cpu_lds_i, cpu_strobe_rel_i} = r[7:4];
		{ym_rw_i, ym_rw_rel_i, cpu_rw_i, cpu_rw_rel_i} = r[11:8];
		{ym_mreq_i, ym_zstb_rel_i, z80_mreq_i, z80_zstb_rel_i} = r[15:12];
		{z80_iorq_i, z80_iorq_rel_i, ym_dtack_pull_i, ext_dtack_i} = r[19:16];
		{ym_bgack_pull_i, ym_br_pull_i, ym_reset_pull_i, cpu_reset_pull_i} = r[23:20];
		{ym_halt_pull_i, cpu_halt_pull_i, ext_vres_i} = r[26:24];
		drive_z_ops(r[28:27], r[30:29]);
	endtask

	task automatic rand_audio();
		logic [31:0] r;
		logic [31:0] s;
		r = $random(seed);
		s = $random(seed);
		{mor_i, mol_i} = r[17:0];
		psg_i = s[15:0];
		r = $random(seed);
		{mor_2612_i, mol_2612_i} = r[19:0];
	endtask

	// test sequence, returns early when a wait times out
	task automatic run_tests();
		bit ok;
		wait_zd_ones("reset", ok);
		if (!ok)
			return;
		next_cycle();
		finish_test("reset state");
		for (int i = 0; i < 300; i++)
		begin
			next_cycle();
			rand_buses();
		end
		finish_test("68k and Z80 address merges");
		for (int i = 0; i < 300; i++)
		begin
			next_cycle();
			rand_zdata();
		end
		// drop every Z80 data driver after random traffic
		next_cycle();
		{ym_zd_rel_i, z80_zd_rel_i, zram_i} = 3'b111;
		wait_zd_ones("release of every Z80 data driver", ok);
		if (!ok)
			return;
		finish_test("Z80 data merge");
		for (int i = 0; i < 200; i++)
		begin
			next_cycle();
			rand_strobes();
		end
		finish_test("strobes, reset and halt");
		for (int i = 0; i < 300; i++)
		begin
			next_cycle();
			rand_buses();
			rand_zdata();
			rand_strobes();
			{uwr_i, lwr_i, ras0_i, ia14_i, zram_i} = 5'($random(seed));
		end
		finish_test("RAM port mapping");
		for (int i = 0; i < 200; i++)
		begin
			next_cycle();
			rand_audio();
		end
		finish_test("audio mix");
	endtask

	initial
	begin
		set_idle();
		reset_i = 1'b1;
		repeat (2) @(posedge MCLK2);
		#1;
		reset_i = 1'b0;
		run_tests();
		repeat (2) next_cycle();
		end_run();
	end

endmodule

//--- flist.f
src/bus_pkg.sv
src/audio_pkg.sv
src/bus_merge.sv
src/bus_ctrl.sv
src/audio_mix.sv
src/md_glue.sv
bench/tb_md_glue.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the md_glue testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_md_glue -f flist.f -o tb_md_glue > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_md_glue > sim.log 2>&1 \
	&& cat sim.log \
	&& ! grep -q '\*\*\* FAILED \*\*\*' sim.log \
	&& echo "simulation passed" && exit 0
cat sim.log
echo "simulation failed"
exit 1
